// ==== core_io_block.sv ====
`timescale 1ns/1ps

module core_io_block
  import io_pkg::*;
#(
  parameter int                core_id        = 0,
  parameter logic [addr_w-1:0] coherent_start = 16'h6FFF,
  parameter int                dmem_addr_w    = msg_addr_w
) (
  input  logic        clk,
  input  logic        rst,
  input  logic        timer_rst,
  input  io_cmd_t     cmd,
  output io_rsp_t     rsp,
  input  logic [63:0] in_desc,
  input  logic        in_desc_valid,
  output logic        in_desc_taken,
  input  logic [4:0]  recv_dram_tag,
  input  logic        recv_dram_tag_valid,
  output logic [63:0] data_desc,
  output logic        data_desc_valid,
  output logic [63:0] dram_wr_addr,
  input  logic        data_desc_ready,
  output core_msg_t   core_msg,
  input  logic        core_msg_ready,
  input  logic        interrupt_in,
  output logic        interrupt_in_ack,
  output logic        timer_irq,
  output logic        ext_irq
);

  io_wr_t      wr;
  io_rd_t      rd;
  logic [7:0]  mask;
  logic [63:0] timer;
  logic        timer_irq_raw;
  logic [31:0] flags;
  logic        flags_any;
  logic [15:0] int_status;

  io_decode u_decode (.cmd(cmd), .wr(wr), .rd(rd));

  io_write_regs u_write_regs (
    .clk              (clk),
    .rst              (rst),
    .wr               (wr),
    .data_desc_ready  (data_desc_ready),
    .data_desc        (data_desc),
    .data_desc_valid  (data_desc_valid),
    .dram_wr_addr     (dram_wr_addr),
    .mask             (mask),
    .in_desc_taken    (in_desc_taken),
    .interrupt_in_ack (interrupt_in_ack)
  );

  interval_timer u_timer (
    .clk(clk), .rst(rst), .timer_rst(timer_rst), .wr(wr),
    .timer(timer), .timer_irq(timer_irq_raw)
  );

  dram_recv_flags u_flags (
    .clk(clk), .rst(rst), .wr(wr), .recv_dram_tag(recv_dram_tag),
    .recv_dram_tag_valid(recv_dram_tag_valid), .flags(flags)
  );

  io_read_mux #(.core_id(core_id)) u_read_mux (
    .clk(clk), .rst(rst), .rd(rd), .in_desc(in_desc), .in_desc_valid(in_desc_valid),
    .flags(flags), .data_desc_ready(data_desc_ready), .core_msg_ready(core_msg_ready),
    .timer(timer), .int_status(int_status), .rsp(rsp)
  );

  ////////////////////////////////
  // Interrupts; mask bits 3 to 0 only read back
  assign flags_any  = |flags;
  assign int_status = {mask, in_desc_valid, flags_any, timer_irq_raw, interrupt_in, 4'd0};
  assign timer_irq  = timer_irq_raw && mask[mask_timer_bit];
  assign ext_irq    = (interrupt_in && mask[mask_ext_bit]) ||
                      (flags_any && mask[mask_dram_bit]) ||
                      (in_desc_valid && mask[mask_desc_bit]);

  // Writes into the coherent region go out unregistered
  assign core_msg.valid = cmd.valid && cmd.wr && (cmd.addr >= coherent_start) &&
                          (32'(cmd.addr) < (32'd1 << dmem_addr_w));
  assign core_msg.addr  = cmd.addr[msg_addr_w-1:0];
  assign core_msg.data  = cmd.wdata;
  assign core_msg.strb  = cmd.addr[2] ? wr.byte_mask[7:4] : wr.byte_mask[3:0];

endmodule

// ==== dram_recv_flags.sv ====
`timescale 1ns/1ps

module dram_recv_flags
  import io_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  io_wr_t      wr,
  input  logic [4:0]  recv_dram_tag,
  input  logic        recv_dram_tag_valid,
  output logic [31:0] flags
);

  logic [4:0]  tag_r;
  logic        tag_valid_r;
  logic [31:0] flags_r;

  // Input stage, for timing
  always_ff @(posedge clk) begin
    tag_r <= recv_dram_tag;
    if (rst) begin
      tag_valid_r <= 1'b0;
    end else begin
      tag_valid_r <= recv_dram_tag_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      flags_r <= 32'd0;
    end else begin
      for (int i = 0; i < 4; i++) begin
        if (wr.dram_flags && wr.byte_mask[i]) begin
          flags_r[i*8 +: 8] <= wr.data64[i*8 +: 8];
        end
      end
      if (wr.flag_rst) begin
        flags_r[wr.data64[20:16]] <= 1'b0;
      end
      // Arriving tag beats a software clear of the same bit
      if (tag_valid_r) begin
        flags_r[tag_r] <= 1'b1;
      end
      flags_r[0] <= 1'b0;  // tag 0 is never used
    end
  end

  assign flags = flags_r;

endmodule

// ==== interval_timer.sv ====
`timescale 1ns/1ps

module interval_timer
  import io_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        timer_rst,
  input  io_wr_t      wr,
  output logic [63:0] timer,
  output logic        timer_irq
);

  logic [63:0] free_cnt;
  logic [31:0] step_r;
  logic [31:0] interval_cnt;
  logic        irq_r;

  // Free-running count, cleared only by its own reset
  always_ff @(posedge clk) begin
    if (timer_rst) begin
      free_cnt <= 64'd0;
    end else begin
      free_cnt <= free_cnt + 64'd1;
    end
  end

  ////////////////////////////////
  // Step register, written through the upper lane
  always_ff @(posedge clk) begin
    if (rst) begin
      step_r <= step_reset;
    end else if (wr.timer_step) begin
      for (int i = 4; i < 8; i++) begin
        if (wr.byte_mask[i]) begin
          step_r[(i-4)*8 +: 8] <= wr.data64[i*8 +: 8];
        end
      end
    end
  end

  // Period is step + 1 cycles; a new step restarts the interval
  always_ff @(posedge clk) begin
    if (rst || wr.timer_step) begin
      interval_cnt <= 32'd0;
      irq_r        <= 1'b0;
    end else if (interval_cnt == step_r) begin
      interval_cnt <= 32'd0;
      irq_r        <= 1'b1;
    end else begin
      interval_cnt <= interval_cnt + 32'd1;
      if (wr.irq_ack && wr.data64[ack_timer_bit]) begin
        irq_r <= 1'b0;
      end
    end
  end

  assign timer     = free_cnt;
  assign timer_irq = irq_r;

endmodule

// ==== io_decode.sv ====
`timescale 1ns/1ps

module io_decode
  import io_pkg::*;
(
  input  io_cmd_t cmd,
  output io_wr_t  wr,
  output io_rd_t  rd
);

  logic       io_sel;
  logic       io_write;
  logic       io_read;
  logic [6:0] off;
  logic [3:0] word_mask;

  assign io_sel   = cmd.addr[io_sel_bit];
  assign io_write = cmd.valid && cmd.wr && io_sel;
  assign io_read  = cmd.valid && !cmd.wr && io_sel;
  assign off      = cmd.addr[6:0];

  // Byte enables within the 32-bit word, for any valid write
  always_comb begin
    word_mask = 4'h0;
    if (cmd.valid && cmd.wr) begin
      case (cmd.size)
        2'd0:    word_mask = 4'b0001 << cmd.addr[1:0];
        2'd1:    word_mask = 4'b0011 << cmd.addr[1:0];
        default: word_mask = 4'b1111;
      endcase
    end
  end

  ////////////////////////////////
  // Write enables
  always_comb begin
    wr.data_desc    = io_write && (off[6:3] == data_desc_off[6:3]);
    wr.dram_addr    = io_write && (off[6:3] == dram_addr_off[6:3]);
    wr.timer_step   = io_write && (off[6:2] == timer_step_off[6:2]);
    wr.dram_flags   = io_write && (off[6:2] == dram_flags_off[6:2]);
    wr.send_desc    = io_write && (off == send_desc_off);
    wr.rd_desc_done = io_write && (off == rd_desc_done_off);
    wr.flag_rst     = io_write && (off == flag_rst_off);
    wr.mask_wr      = io_write && (off == mask_wr_off);
    wr.irq_ack      = io_write && (off == irq_ack_off);
    // Upper lane of the 64-bit registers when address bit 2 is set
    wr.byte_mask    = {4'd0, word_mask} << {cmd.addr[2], 2'b00};
    wr.data64       = {cmd.wdata, cmd.wdata};
  end

  ////////////////////////////////
  // Read selects
  always_comb begin
    rd.in_desc = io_read && (off[6:3] == in_desc_off[6:3]);
    rd.flags   = io_read && (off[6:2] == rd_flags_off[6:2]);
    rd.stat    = io_read && (off[6:2] == rd_stat_off[6:2]);
    rd.id      = io_read && (off[6:2] == rd_id_off[6:2]);
    rd.timer_l = io_read && (off[6:2] == rd_timer_l_off[6:2]);
    rd.timer_h = io_read && (off[6:2] == rd_timer_h_off[6:2]);
    rd.int_st  = io_read && (off[6:2] == rd_int_off[6:2]);
    rd.hi_word = cmd.addr[2];
  end

endmodule

// ==== io_pkg.sv ====
package io_pkg;

  // Bus geometry
  localparam int addr_w     = 16;
  localparam int io_sel_bit = 15;
  localparam int msg_addr_w = 15;

  ////////////////////////////////
  // Write side of I/O space, address bits 6 to 0
  localparam logic [6:0] data_desc_off  = 7'h00;
  localparam logic [6:0] dram_addr_off  = 7'h08;
  localparam logic [6:0] timer_step_off = 7'h14;
  localparam logic [6:0] dram_flags_off = 7'h18;

  // Single-address strobes
  localparam logic [6:0] send_desc_off    = 7'h38;
  localparam logic [6:0] rd_desc_done_off = 7'h39;
  localparam logic [6:0] flag_rst_off     = 7'h3A;
  localparam logic [6:0] mask_wr_off      = 7'h3C;
  localparam logic [6:0] irq_ack_off      = 7'h3D;

  ////////////////////////////////
  // Read side of I/O space
  localparam logic [6:0] in_desc_off    = 7'h40;
  localparam logic [6:0] rd_flags_off   = 7'h48;
  localparam logic [6:0] rd_stat_off    = 7'h4C;
  localparam logic [6:0] rd_id_off      = 7'h50;
  localparam logic [6:0] rd_timer_l_off = 7'h54;
  localparam logic [6:0] rd_timer_h_off = 7'h58;
  localparam logic [6:0] rd_int_off     = 7'h5C;

  // Timer, DRAM and incoming descriptor interrupts start blocked
  localparam logic [7:0]  mask_reset = 8'h1F;
  localparam logic [31:0] step_reset = 32'd1;

  localparam int mask_ext_bit   = 4;
  localparam int mask_timer_bit = 5;
  localparam int mask_dram_bit  = 6;
  localparam int mask_desc_bit  = 7;

  // Bits of the acknowledge word
  localparam int ack_ext_bit   = 12;
  localparam int ack_timer_bit = 13;

  typedef struct packed {
    logic              valid;
    logic              wr;
    logic [1:0]        size;
    logic [addr_w-1:0] addr;
    logic [31:0]       wdata;
  } io_cmd_t;

  typedef struct packed {
    logic        data_desc;
    logic        dram_addr;
    logic        timer_step;
    logic        dram_flags;
    logic        send_desc;
    logic        rd_desc_done;
    logic        flag_rst;
    logic        mask_wr;
    logic        irq_ack;
    logic [7:0]  byte_mask;
    logic [63:0] data64;
  } io_wr_t;

  typedef struct packed {
    logic in_desc;
    logic flags;
    logic stat;
    logic id;
    logic timer_l;
    logic timer_h;
    logic int_st;
    logic hi_word;
  } io_rd_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] data;
  } io_rsp_t;

  typedef struct packed {
    logic                  valid;
    logic [msg_addr_w-1:0] addr;
    logic [31:0]           data;
    logic [3:0]            strb;
  } core_msg_t;

endpackage

// ==== io_read_mux.sv ====
`timescale 1ns/1ps

module io_read_mux
  import io_pkg::*;
#(
  parameter int core_id = 0
) (
  input  logic        clk,
  input  logic        rst,
  input  io_rd_t      rd,
  input  logic [63:0] in_desc,
  input  logic        in_desc_valid,
  input  logic [31:0] flags,
  input  logic        data_desc_ready,
  input  logic        core_msg_ready,
  input  logic [63:0] timer,
  input  logic [15:0] int_status,
  output io_rsp_t     rsp
);

  logic        any_sel;
  logic [31:0] stat_word;
  logic [31:0] rd_word;
  logic        rsp_valid_r;
  logic [31:0] rsp_data_r;

  assign any_sel = rd.in_desc || rd.flags || rd.stat || rd.id ||
                   rd.timer_l || rd.timer_h || rd.int_st;

  // Bit 16 was the slot table ready, now always 0
  assign stat_word = {7'd0, core_msg_ready, 7'd0, 1'b0,
                      7'd0, data_desc_ready, 7'd0, in_desc_valid};

  ////////////////////////////////
  // Word selection
  always_comb begin
    rd_word = 32'd0;
    if (rd.in_desc) begin
      if (in_desc_valid) begin
        rd_word = rd.hi_word ? in_desc[63:32] : in_desc[31:0];
      end
    end else if (rd.flags) begin
      rd_word = flags;
    end else if (rd.stat) begin
      rd_word = stat_word;
    end else if (rd.id) begin
      rd_word = 32'(core_id);
    end else if (rd.timer_l) begin
      rd_word = timer[31:0];
    end else if (rd.timer_h) begin
      rd_word = timer[63:32];
    end else if (rd.int_st) begin
      rd_word = {16'd0, int_status};
    end
  end

  // Response one cycle after the read
  always_ff @(posedge clk) begin
    if (rst) begin
      rsp_valid_r <= 1'b0;
    end else begin
      rsp_valid_r <= any_sel;
    end
  end

  always_ff @(posedge clk) begin
    if (any_sel) begin
      rsp_data_r <= rd_word;
    end
  end

  assign rsp = '{valid: rsp_valid_r, data: rsp_data_r};

endmodule

// ==== io_write_regs.sv ====
`timescale 1ns/1ps

module io_write_regs
  import io_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  io_wr_t      wr,
  input  logic        data_desc_ready,
  output logic [63:0] data_desc,
  output logic        data_desc_valid,
  output logic [63:0] dram_wr_addr,
  output logic [7:0]  mask,
  output logic        in_desc_taken,
  output logic        interrupt_in_ack
);

  logic [63:0] data_desc_r;
  logic [63:0] dram_addr_r;
  logic [7:0]  mask_r;
  logic        desc_valid_r;
  logic        ack_r;
  logic        strb_set;

  // Strobe writes carry their flag in data bit 0
  assign strb_set = wr.data64[0];

  ////////////////////////////////
  // Byte-writable payload registers
  always_ff @(posedge clk) begin
    for (int i = 0; i < 8; i++) begin
      if (wr.data_desc && wr.byte_mask[i]) begin
        data_desc_r[i*8 +: 8] <= wr.data64[i*8 +: 8];
      end
      if (wr.dram_addr && wr.byte_mask[i]) begin
        dram_addr_r[i*8 +: 8] <= wr.data64[i*8 +: 8];
      end
    end
  end

  // Mask lives in byte lane 4
  always_ff @(posedge clk) begin
    if (rst) begin
      mask_r <= mask_reset;
    end else if (wr.mask_wr && wr.byte_mask[4]) begin
      mask_r <= wr.data64[39:32];
    end
  end

  ////////////////////////////////
  // Outgoing descriptor valid, held until accepted
  always_ff @(posedge clk) begin
    if (rst) begin
      desc_valid_r <= 1'b0;
    end else begin
      if (wr.send_desc && strb_set) begin
        desc_valid_r <= 1'b1;
      end
      if (desc_valid_r && data_desc_ready) begin
        desc_valid_r <= 1'b0;
      end
    end
  end

  // External interrupt ack, one cycle after the ack write
  always_ff @(posedge clk) begin
    if (rst) begin
      ack_r <= 1'b0;
    end else begin
      ack_r <= wr.irq_ack && wr.data64[ack_ext_bit];
    end
  end

  assign data_desc        = data_desc_r;
  assign data_desc_valid  = desc_valid_r;
  assign dram_wr_addr     = dram_addr_r;
  assign mask             = mask_r;
  assign in_desc_taken    = wr.rd_desc_done && strb_set;
  assign interrupt_in_ack = ack_r;

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build with Verilator, run, and judge the run from its log
rm -f sim.log
verilator --binary --timing --assert --top-module tb_core_io_block -f tb.f -o tb_sim \
  && ./obj_dir/tb_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qs "^sim passed$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// ==== tb.f ====
io_pkg.sv
io_decode.sv
io_write_regs.sv
interval_timer.sv
dram_recv_flags.sv
io_read_mux.sv
core_io_block.sv
tb_core_io_block.sv

// ==== tb_core_io_block.sv ====
`timescale 1ns/1ps

module tb_core_io_block
  import io_pkg::*;
();

  localparam int unsigned     seed           = 45776;
  localparam logic [15:0]     coherent_start = 16'h7000;
  // About 150 cycles of tests, doubled for margin
  localparam int              run_cycles     = 150;
  localparam int              cycle_limit    = 2 * run_cycles;

  logic clk;
  logic rst;
  logic timer_rst;
  io_cmd_t cmd;
  io_rsp_t rsp;
  logic [63:0] in_desc;
  logic in_desc_valid;
  logic in_desc_taken;
  logic [4:0] recv_dram_tag;
  logic recv_dram_tag_valid;
  logic [63:0] data_desc;
  logic data_desc_valid;
  logic [63:0] dram_wr_addr;
  logic data_desc_ready;
  core_msg_t core_msg;
  logic core_msg_ready;
  logic interrupt_in;
  logic interrupt_in_ack;
  logic timer_irq;
  logic ext_irq;

  int cycles;
  int assert_errors;
  int check_errors;

  core_io_block #(
    .core_id        (5),
    .coherent_start (coherent_start),
    .dmem_addr_w    (15)
  ) dut0 (
    .clk(clk), .rst(rst), .timer_rst(timer_rst), .cmd(cmd), .rsp(rsp),
    .in_desc(in_desc), .in_desc_valid(in_desc_valid), .in_desc_taken(in_desc_taken),
    .recv_dram_tag(recv_dram_tag), .recv_dram_tag_valid(recv_dram_tag_valid),
    .data_desc(data_desc), .data_desc_valid(data_desc_valid),
    .dram_wr_addr(dram_wr_addr), .data_desc_ready(data_desc_ready),
    .core_msg(core_msg), .core_msg_ready(core_msg_ready), .interrupt_in(interrupt_in),
    .interrupt_in_ack(interrupt_in_ack), .timer_irq(timer_irq), .ext_irq(ext_irq)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Byte lanes touched within a 32-bit word
  function automatic logic [3:0] lane_strb(input logic [1:0] size, input logic [1:0] low);
    case (size)
      2'd0:    lane_strb = 4'b0001 << low;
      2'd1:    lane_strb = 4'b0011 << low;
      default: lane_strb = 4'b1111;
    endcase
  endfunction

  function automatic logic [15:0] io_addr(input logic [6:0] off);
    io_addr = {1'b1, 8'd0, off};
  endfunction

  function automatic logic [63:0] merge_bytes(input logic [63:0] old, input logic [2:0] low3,
                                              input logic [1:0] size, input logic [31:0] data);
    logic [63:0] res;
    logic [3:0]  strb;
    res  = old;
    strb = lane_strb(size, low3[1:0]);
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        res[(int'(low3[2]) * 4 + b) * 8 +: 8] = data[b*8 +: 8];
      end
    end
    return res;
  endfunction

  ////////////////////////////////
  // Expected bus events
  logic       io_rd_cmd;
  logic       io_wr_cmd;
  logic       send_cmd;
  logic       taken_cmd;
  logic       ack_ext_cmd;
  logic       msg_cmd;
  logic [3:0] exp_strb;

  assign io_rd_cmd   = cmd.valid && !cmd.wr && cmd.addr[io_sel_bit];
  assign io_wr_cmd   = cmd.valid && cmd.wr && cmd.addr[io_sel_bit];
  assign send_cmd    = io_wr_cmd && (cmd.addr[6:0] == send_desc_off) && cmd.wdata[0];
  assign taken_cmd   = io_wr_cmd && (cmd.addr[6:0] == rd_desc_done_off) && cmd.wdata[0];
  assign ack_ext_cmd = io_wr_cmd && (cmd.addr[6:0] == irq_ack_off) && cmd.wdata[ack_ext_bit];
  assign msg_cmd     = cmd.valid && cmd.wr && (cmd.addr >= coherent_start) &&
                       (cmd.addr < 16'h8000);
  assign exp_strb    = lane_strb(cmd.size, cmd.addr[1:0]);

  rsp_timing: assert property (@(posedge clk) disable iff (rst) rsp.valid == $past(io_rd_cmd))
    else begin
      assert_errors++;
      $display("ERROR %0t: rsp.valid not exactly one cycle after a read", $time);
    end

  desc_hold: assert property (@(posedge clk) disable iff (rst)
    $past(data_desc_valid && !data_desc_ready) |-> data_desc_valid)
    else begin
      assert_errors++;
      $display("ERROR %0t: data_desc_valid dropped while ready was low", $time);
    end

  desc_release: assert property (@(posedge clk) disable iff (rst)
    $past(data_desc_valid && data_desc_ready) |-> !data_desc_valid)
    else begin
      assert_errors++;
      $display("ERROR %0t: data_desc_valid still high after handshake", $time);
    end

  desc_raise: assert property (@(posedge clk) disable iff (rst)
    $past(send_cmd && !(data_desc_valid && data_desc_ready)) |-> data_desc_valid)
    else begin
      assert_errors++;
      $display("ERROR %0t: data_desc_valid did not rise after send", $time);
    end

  taken_pulse: assert property (@(posedge clk) disable iff (rst) in_desc_taken == taken_cmd)
    else begin
      assert_errors++;
      $display("ERROR %0t: in_desc_taken is %b, expected %b", $time, in_desc_taken, taken_cmd);
    end

  ack_pulse: assert property (@(posedge clk) disable iff (rst)
    interrupt_in_ack == $past(ack_ext_cmd))
    else begin
      assert_errors++;
      $display("ERROR %0t: interrupt_in_ack not one cycle after the ack write", $time);
    end

  msg_valid: assert property (@(posedge clk) disable iff (rst) core_msg.valid == msg_cmd)
    else begin
      assert_errors++;
      $display("ERROR %0t: core_msg.valid is %b, expected %b", $time, core_msg.valid, msg_cmd);
    end

  msg_fields: assert property (@(posedge clk) disable iff (rst)
    msg_cmd |-> (core_msg.addr == cmd.addr[msg_addr_w-1:0] && core_msg.data == cmd.wdata &&
                 core_msg.strb == exp_strb))
    else begin
      assert_errors++;
      $display("ERROR %0t: core_msg fields do not match the write", $time);
    end

  ////////////////////////////////
  // Bus and check tasks, all entered on a falling edge
  task automatic bus_write(input logic [15:0] addr, input logic [31:0] data,
                           input logic [1:0] size);
    cmd.valid = 1'b1;
    cmd.wr    = 1'b1;
    cmd.size  = size;
    cmd.addr  = addr;
    cmd.wdata = data;
    @(negedge clk);
    cmd = '0;
  endtask

  task automatic bus_read(input logic [6:0] off, output logic [31:0] data);
    cmd.valid = 1'b1;
    cmd.wr    = 1'b0;
    cmd.size  = 2'd2;
    cmd.addr  = io_addr(off);
    cmd.wdata = 32'd0;
    @(negedge clk);
    cmd  = '0;
    data = rsp.data;
  endtask

  task automatic check_word(input string what, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      check_errors++;
      $display("ERROR %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_bit(input string what, input logic got, input logic exp);
    assert (got === exp) else begin
      check_errors++;
      $display("ERROR %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic pulse_tag(input logic [4:0] tag);
    recv_dram_tag       = tag;
    recv_dram_tag_valid = 1'b1;
    @(negedge clk);
    recv_dram_tag_valid = 1'b0;
  endtask

  task automatic check_status(input logic msg_rdy, input logic desc_rdy, input logic in_vld);
    logic [31:0] word;
    core_msg_ready  = msg_rdy;
    data_desc_ready = desc_rdy;
    in_desc_valid   = in_vld;
    bus_read(rd_stat_off, word);
    check_word("status word", word, {7'd0, msg_rdy, 15'd0, desc_rdy, 7'd0, in_vld});
  endtask

  task automatic check_reset_state();
    logic [31:0] word;
    check_bit("rsp.valid after reset", rsp.valid, 1'b0);
    check_bit("data_desc_valid after reset", data_desc_valid, 1'b0);
    check_bit("in_desc_taken after reset", in_desc_taken, 1'b0);
    check_bit("interrupt_in_ack after reset", interrupt_in_ack, 1'b0);
    check_bit("timer_irq after reset", timer_irq, 1'b0);
    check_bit("ext_irq after reset", ext_irq, 1'b0);
    check_bit("core_msg.valid after reset", core_msg.valid, 1'b0);
    bus_read(rd_int_off, word);
    check_word("mask after reset", {24'd0, word[15:8]}, 32'h1F);
  endtask

  ////////////////////////////////
  // Outgoing descriptor and DRAM address
  task automatic test_desc_out();
    logic [63:0] model;
    logic [31:0] data;
    logic [2:0]  low3;
    logic [1:0]  size;
    int          wait_cycles;
    // Two full words first so no byte of the model is unknown
    data = $urandom();
    bus_write(io_addr(data_desc_off), data, 2'd2);
    model[31:0] = data;
    data = $urandom();
    bus_write(io_addr(data_desc_off + 7'd4), data, 2'd2);
    model[63:32] = data;
    repeat (12) begin
      size = 2'($urandom_range(2, 0));
      low3 = 3'($urandom_range(7, 0));
      if (size == 2'd1) low3[0] = 1'b0;
      if (size == 2'd2) low3[1:0] = 2'b00;
      data = $urandom();
      bus_write(io_addr(data_desc_off | {4'd0, low3}), data, size);
      model = merge_bytes(model, low3, size, data);
    end
    check_word("data_desc low", data_desc[31:0], model[31:0]);
    check_word("data_desc high", data_desc[63:32], model[63:32]);
    data_desc_ready = 1'b0;
    bus_write(io_addr(send_desc_off), 32'd1, 2'd2);
    check_bit("data_desc_valid after send", data_desc_valid, 1'b1);
    repeat (3) @(negedge clk);
    data_desc_ready = 1'b1;
    wait_cycles = 0;
    while (data_desc_valid && wait_cycles < 8) begin
      @(negedge clk);
      wait_cycles++;
    end
    if (data_desc_valid) begin
      check_errors++;
      $display("data_desc_valid never fell after the handshake");
    end
    data = $urandom();
    bus_write(io_addr(dram_addr_off), data, 2'd2);
    check_word("dram_wr_addr low", dram_wr_addr[31:0], data);
    data = $urandom();
    bus_write(io_addr(dram_addr_off + 7'd4), data, 2'd2);
    check_word("dram_wr_addr high", dram_wr_addr[63:32], data);
  endtask

  // ID, status and incoming descriptor
  task automatic test_reads();
    logic [63:0] desc;
    logic [31:0] word;
    bus_read(rd_id_off, word);
    check_word("core id", word, 32'd5);
    check_status(1'b1, 1'b0, 1'b1);
    check_status(1'b0, 1'b1, 1'b0);
    desc          = {$urandom(), $urandom()};
    in_desc       = desc;
    in_desc_valid = 1'b1;
    bus_read(in_desc_off, word);
    check_word("in_desc low word", word, desc[31:0]);
    bus_read(in_desc_off + 7'd4, word);
    check_word("in_desc high word", word, desc[63:32]);
    bus_write(io_addr(rd_desc_done_off), 32'd1, 2'd2);
    bus_write(io_addr(rd_desc_done_off), 32'd0, 2'd2);
    in_desc_valid = 1'b0;
    bus_read(in_desc_off, word);
    check_word("in_desc read with no descriptor", word, 32'd0);
  endtask

  // DRAM receive flags and the DRAM interrupt
  task automatic test_flags();
    logic [31:0] model;
    logic [31:0] word;
    logic [4:0]  tag;
    model = 32'd0;
    bus_write(io_addr(mask_wr_off), 32'h40, 2'd2);
    check_bit("ext_irq with no flags", ext_irq, 1'b0);
    // Flag is set at the second edge after the pulse
    tag = 5'd9;
    pulse_tag(tag);
    bus_read(rd_flags_off, word);
    check_word("flags one edge after tag", word, model);
    model[tag] = 1'b1;
    bus_read(rd_flags_off, word);
    check_word("flags two edges after tag", word, model);
    pulse_tag(5'd0);
    repeat (6) begin
      tag = 5'($urandom_range(31, 0));
      pulse_tag(tag);
      if (tag != 5'd0) model[tag] = 1'b1;
    end
    @(negedge clk);
    bus_read(rd_flags_off, word);
    check_word("flags after tag burst", word, model);
    check_bit("ext_irq from flags", ext_irq, |model);
    bus_write(io_addr(flag_rst_off), 32'h0009_0000, 2'd2);
    model[9] = 1'b0;
    bus_read(rd_flags_off, word);
    check_word("flags after flag reset", word, model);
    bus_write(io_addr(dram_flags_off), 32'd0, 2'd2);
    check_bit("ext_irq with flags cleared", ext_irq, 1'b0);
    // External line only reaches ext_irq through mask bit 4
    interrupt_in = 1'b1;
    check_bit("ext_irq with interrupt_in masked", ext_irq, 1'b0);
    bus_write(io_addr(mask_wr_off), 32'h10, 2'd2);
    check_bit("ext_irq from interrupt_in", ext_irq, 1'b1);
    interrupt_in = 1'b0;
  endtask

  // Periodic timer interrupt and acknowledges
  task automatic test_timer_irq();
    logic [31:0] step;
    logic [31:0] word;
    int          cycles_to_irq;
    step = 32'($urandom_range(10, 3));
    // Bits 3 and 1 only read back
    bus_write(io_addr(mask_wr_off), 32'h2A, 2'd2);
    bus_read(rd_int_off, word);
    check_word("mask readback", {24'd0, word[15:8]}, 32'h2A);
    bus_write(io_addr(timer_step_off), step, 2'd2);
    check_bit("timer_irq after step write", timer_irq, 1'b0);
    cycles_to_irq = 0;
    while (!timer_irq && cycles_to_irq < 64) begin
      @(negedge clk);
      cycles_to_irq++;
    end
    check_word("cycles from step write to timer_irq", 32'(cycles_to_irq), step + 32'd1);
    bus_write(io_addr(irq_ack_off), 32'h2000, 2'd2);
    check_bit("timer_irq after ack", timer_irq, 1'b0);
    bus_write(io_addr(irq_ack_off), 32'h1000, 2'd2);
    check_bit("interrupt_in_ack after ack write", interrupt_in_ack, 1'b1);
    @(negedge clk);
    check_bit("interrupt_in_ack one cycle wide", interrupt_in_ack, 1'b0);
  endtask

  // Core messages, then the free-running timer
  task automatic test_msg_timer();
    logic [15:0] addr;
    logic [31:0] word;
    logic [31:0] prev;
    logic [1:0]  size;
    bus_write(coherent_start, $urandom(), 2'd2);
    repeat (6) begin
      size = 2'($urandom_range(2, 0));
      addr = coherent_start + 16'($urandom_range(4095, 0));
      if (size == 2'd1) addr[0] = 1'b0;
      if (size == 2'd2) addr[1:0] = 2'b00;
      bus_write(addr, $urandom(), size);
      bus_write(addr - 16'h6000, $urandom(), size);
    end
    timer_rst = 1'b1;
    @(negedge clk);
    timer_rst = 1'b0;
    bus_read(rd_timer_l_off, prev);
    check_bit("timer low word restarts after timer_rst", prev < 32'd4, 1'b1);
    repeat (4) begin
      repeat ($urandom_range(3, 0)) @(negedge clk);
      bus_read(rd_timer_l_off, word);
      check_bit("timer low word increases", word > prev, 1'b1);
      prev = word;
    end
  endtask

  initial begin
    void'($urandom(seed));
    assert_errors       = 0;
    check_errors        = 0;
    rst                 = 1'b1;
    timer_rst           = 1'b1;
    cmd                 = '0;
    in_desc             = 64'd0;
    in_desc_valid       = 1'b0;
    recv_dram_tag       = 5'd0;
    recv_dram_tag_valid = 1'b0;
    data_desc_ready     = 1'b0;
    core_msg_ready      = 1'b0;
    interrupt_in        = 1'b0;
    repeat (4) @(negedge clk);
    rst       = 1'b0;
    timer_rst = 1'b0;
    check_reset_state();
    test_desc_out();
    test_reads();
    test_flags();
    test_timer_irq();
    test_msg_timer();
    @(negedge clk);
    $display("errors: %0d from assertions, %0d from checks", assert_errors, check_errors);
    if (assert_errors == 0 && check_errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  // Run limit
  initial begin
    cycles = 0;
    while (cycles < cycle_limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: tests did not finish within %0d cycles", cycle_limit);
    $display("sim failed");
    $finish;
  end

endmodule
